// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := fedp_tb
FILELIST  := fedp_top.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+100
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/fedp_pkg.sv
/*
 * Shared definitions of the dot-product engine
 *  - lane count and datapath widths
 *  - half-precision operand layout
 *  - unaligned term and result structs
 */
package fedp_pkg;

    // Four product lanes plus the C lane
    localparam int num_terms = 5;

    localparam int exp_w  = 10;
    localparam int mag_w  = 22;
    localparam int sum_w  = 27;
    localparam int tag_w  = 26;

    // Half-precision field widths
    localparam int hexp_w = 5;
    localparam int frac_w = 10;

    // Integer mode operand width
    localparam int int_op_w = 8;

    typedef struct packed {
        logic              sign;
        logic [hexp_w-1:0] exp;
        logic [frac_w-1:0] frac;
    } fp_op_t;

    // Sign-magnitude term before alignment
    typedef struct packed {
        logic             sign;
        logic [exp_w-1:0] exp;
        logic [mag_w-1:0] mag;
    } term_t;

    typedef struct packed {
        logic signed [sum_w-1:0] sum;
        logic [exp_w-1:0]        max_exp;
        logic                    sticky;
        logic                    is_int;
        logic [tag_w-1:0]        tag;
    } result_t;

endpackage

// File: design/fedp_exp_max.sv
`timescale 1ns/10ps

/*
 * Second stage of the dot-product engine
 *  - maximum exponent over all lanes by a comparison tree
 *  - terms delayed alongside the maximum
 */
module fedp_exp_max #(
    parameter int N     = fedp_pkg::num_terms,
    parameter int EXP_W = fedp_pkg::exp_w,
    parameter int MAG_W = fedp_pkg::mag_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic                        is_int,
    input  logic [fedp_pkg::tag_w-1:0]  tag,
    input  fedp_pkg::term_t [N-1:0]     terms,
    output logic                        valid,
    output logic                        is_int_q,
    output logic [fedp_pkg::tag_w-1:0]  tag_q,
    output fedp_pkg::term_t [N-1:0]     terms_q,
    output logic [EXP_W-1:0]            max_exp
);

    // Heap layout: internal nodes 0..N-2, leaves N-1..2N-2
    logic [2*N-2:0][EXP_W-1:0] node;

    for (genvar i = 0; i < N; i++) begin : g_leaf
        assign node[N-1+i] = terms[i].exp;
    end

    for (genvar k = 0; k < N-1; k++) begin : g_cmp
        assign node[k] = (node[2*k+1] > node[2*k+2]) ? node[2*k+1] : node[2*k+2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        is_int_q <= is_int;
        tag_q    <= tag;
        terms_q  <= terms;
        // Integer results have no exponent
        max_exp  <= is_int ? '0 : node[0];
    end

    // Magnitudes only ride along here
    localparam int TERM_BITS = 1 + EXP_W + MAG_W;
    if ($bits(fedp_pkg::term_t) != TERM_BITS) begin : g_width_check
        $error("term width does not match EXP_W and MAG_W");
    end

endmodule

// File: design/fedp_mul.sv
`timescale 1ns/10ps

/*
 * First stage of the dot-product engine
 *  - sign-magnitude products of the half-precision pairs
 *  - exponent sums per lane
 *  - signed 8-bit products in integer mode
 *  - C term placed on the last lane
 */
module fedp_mul #(
    parameter int N     = fedp_pkg::num_terms,
    parameter int EXP_W = fedp_pkg::exp_w,
    parameter int MAG_W = fedp_pkg::mag_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic [fedp_pkg::tag_w-1:0]  tag,
    input  logic                        is_int,
    input  fedp_pkg::fp_op_t [N-2:0]    a_ops,
    input  fedp_pkg::fp_op_t [N-2:0]    b_ops,
    input  fedp_pkg::term_t             c_term,
    output logic                        valid,
    output logic                        is_int_q,
    output logic [fedp_pkg::tag_w-1:0]  tag_q,
    output fedp_pkg::term_t [N-1:0]     terms
);

    fedp_pkg::term_t [N-1:0] terms_d;

    for (genvar i = 0; i < N-1; i++) begin : g_lane
        logic [fedp_pkg::frac_w:0]          sig_a;
        logic [fedp_pkg::frac_w:0]          sig_b;
        logic [MAG_W-1:0]                   sig_prod;
        logic                               op_zero;
        logic signed [2*fedp_pkg::int_op_w-1:0] int_prod;
        fedp_pkg::term_t                    lane_term;

        // Hidden bit restored on both significands
        assign sig_a    = {1'b1, a_ops[i].frac};
        assign sig_b    = {1'b1, b_ops[i].frac};
        assign sig_prod = sig_a * sig_b;

        // No subnormals, a zero exponent field is a zero operand
        assign op_zero = (a_ops[i].exp == '0) || (b_ops[i].exp == '0);

        assign int_prod = $signed(a_ops[i][fedp_pkg::int_op_w-1:0])
                        * $signed(b_ops[i][fedp_pkg::int_op_w-1:0]);

        always_comb begin
            if (is_int) begin
                lane_term.sign = 1'b0;
                lane_term.exp  = '0;
                lane_term.mag  = MAG_W'(int_prod);
            end else begin
                lane_term.sign = a_ops[i].sign ^ b_ops[i].sign;
                lane_term.exp  = EXP_W'(a_ops[i].exp) + EXP_W'(b_ops[i].exp);
                lane_term.mag  = op_zero ? '0 : sig_prod;
            end
        end

        assign terms_d[i] = lane_term;
    end

    // C goes through as is, its low 24 bits carry the integer addend
    assign terms_d[N-1] = c_term;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        is_int_q <= is_int;
        tag_q    <= tag;
        terms    <= terms_d;
    end

endmodule

// File: design/fedp_reduce.sv
`timescale 1ns/10ps

/*
 * Fourth stage of the dot-product engine
 *  - signed adder tree over the aligned lanes
 *  - OR of the lane sticky bits
 *  - result packing
 */
module fedp_reduce #(
    parameter int N     = fedp_pkg::num_terms,
    parameter int EXP_W = fedp_pkg::exp_w,
    parameter int WO    = fedp_pkg::sum_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic                        is_int,
    input  logic [fedp_pkg::tag_w-1:0]  tag,
    input  logic [N-1:0][WO-1:0]        sigs,
    input  logic [N-1:0]                sticky_bits,
    input  logic [EXP_W-1:0]            max_exp,
    output logic                        valid,
    output fedp_pkg::result_t           result
);

    // Same heap layout as the exponent tree, leaves at N-1..2N-2
    logic signed [WO-1:0] node [2*N-1];

    for (genvar i = 0; i < N; i++) begin : g_leaf
        assign node[N-1+i] = $signed(sigs[i]);
    end

    // WO leaves room for the growth of N terms, no overflow
    for (genvar k = 0; k < N-1; k++) begin : g_add
        assign node[k] = node[2*k+1] + node[2*k+2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        result.sum     <= node[0];
        result.max_exp <= max_exp;
        result.sticky  <= |sticky_bits;
        result.is_int  <= is_int;
        result.tag     <= tag;
    end

endmodule

// File: design/fedp_top.sv
`timescale 1ns/10ps

/*
 * Top level of the dot-product engine
 *  - multiply, exponent max, align and reduce stages in a chain
 *  - valid, mode and tag carried stage to stage
 */
module fedp_top #(
    parameter int N  = fedp_pkg::num_terms,
    parameter int WO = fedp_pkg::sum_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic [fedp_pkg::tag_w-1:0]  tag,
    input  logic                        is_int,
    input  fedp_pkg::fp_op_t [N-2:0]    a_ops,
    input  fedp_pkg::fp_op_t [N-2:0]    b_ops,
    input  fedp_pkg::term_t             c_term,
    output logic                        valid_out,
    output fedp_pkg::result_t           result
);

    // Multiply to exponent max
    logic                           mul_valid;
    logic                           mul_is_int;
    logic [fedp_pkg::tag_w-1:0]     mul_tag;
    fedp_pkg::term_t [N-1:0]        mul_terms;

    // Exponent max to align
    logic                           emax_valid;
    logic                           emax_is_int;
    logic [fedp_pkg::tag_w-1:0]     emax_tag;
    fedp_pkg::term_t [N-1:0]        emax_terms;
    logic [fedp_pkg::exp_w-1:0]     emax_exp;

    // Align to reduce
    logic                           algn_valid;
    logic                           algn_is_int;
    logic [fedp_pkg::tag_w-1:0]     algn_tag;
    logic [fedp_pkg::exp_w-1:0]     algn_exp;
    logic [N-1:0][WO-1:0]           algn_sigs;
    logic [N-1:0]                   algn_sticky;

    fedp_mul #(
        .N (N)
    ) fedp_mul_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .tag      (tag),
        .is_int   (is_int),
        .a_ops    (a_ops),
        .b_ops    (b_ops),
        .c_term   (c_term),
        .valid    (mul_valid),
        .is_int_q (mul_is_int),
        .tag_q    (mul_tag),
        .terms    (mul_terms)
    );

    fedp_exp_max #(
        .N (N)
    ) fedp_exp_max_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (mul_valid),
        .is_int   (mul_is_int),
        .tag      (mul_tag),
        .terms    (mul_terms),
        .valid    (emax_valid),
        .is_int_q (emax_is_int),
        .tag_q    (emax_tag),
        .terms_q  (emax_terms),
        .max_exp  (emax_exp)
    );

    fedp_align #(
        .N  (N),
        .WO (WO)
    ) fedp_align_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (emax_valid),
        .is_int      (emax_is_int),
        .tag         (emax_tag),
        .terms       (emax_terms),
        .max_exp     (emax_exp),
        .valid       (algn_valid),
        .is_int_q    (algn_is_int),
        .tag_q       (algn_tag),
        .max_exp_q   (algn_exp),
        .sigs        (algn_sigs),
        .sticky_bits (algn_sticky)
    );

    fedp_reduce #(
        .N  (N),
        .WO (WO)
    ) fedp_reduce_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (algn_valid),
        .is_int      (algn_is_int),
        .tag         (algn_tag),
        .sigs        (algn_sigs),
        .sticky_bits (algn_sticky),
        .max_exp     (algn_exp),
        .valid       (valid_out),
        .result      (result)
    );

endmodule

// File: fedp_align/fedp_align.sv
`timescale 1ns/10ps

/*
 * Third stage of the dot-product engine
 *  - per-lane shift amount, saturated to 255
 *  - right shift with overshift to zero
 *  - sticky bit per lane
 *  - two's-complement conversion, integer bypass
 */
module fedp_align #(
    parameter int N     = fedp_pkg::num_terms,
    parameter int EXP_W = fedp_pkg::exp_w,
    parameter int MAG_W = fedp_pkg::mag_w,
    parameter int WO    = fedp_pkg::sum_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic                        is_int,
    input  logic [fedp_pkg::tag_w-1:0]  tag,
    input  fedp_pkg::term_t [N-1:0]     terms,
    input  logic [EXP_W-1:0]            max_exp,
    output logic                        valid,
    output logic                        is_int_q,
    output logic [fedp_pkg::tag_w-1:0]  tag_q,
    output logic [EXP_W-1:0]            max_exp_q,
    output logic [N-1:0][WO-1:0]        sigs,
    output logic [N-1:0]                sticky_bits
);

    // Width of the signed integer addend on the C lane
    localparam int C_INT_W = 24;

    logic [N-1:0][WO-1:0] sigs_d;
    logic [N-1:0]         sticky_d;

    for (genvar i = 0; i < N; i++) begin : g_lane
        logic [EXP_W-1:0] exp_diff;
        logic [7:0]       shift_amt;
        logic             overshift;
        logic [MAG_W-1:0] mag;
        logic [MAG_W-1:0] mag_shr;
        logic [MAG_W-1:0] lost_mask;
        logic             fp_sticky;
        logic [WO-1:0]    fp_sig;
        logic [WO-1:0]    int_sig;

        assign mag      = terms[i].mag;
        assign exp_diff = max_exp - terms[i].exp;

        // Gaps that need more than 8 bits clamp to 255
        assign shift_amt = (|exp_diff[EXP_W-1:8]) ? 8'hff : exp_diff[7:0];
        assign overshift = (shift_amt >= 8'(MAG_W));

        assign mag_shr   = overshift ? '0 : (mag >> shift_amt);
        // Ones on the bit positions that fall off the right end
        assign lost_mask = ~({MAG_W{1'b1}} << shift_amt);
        assign fp_sticky = overshift ? (|mag) : (|(mag & lost_mask));

        assign fp_sig = terms[i].sign ? -WO'(mag_shr) : WO'(mag_shr);

        if (i == N-1) begin : g_c_lane
            assign int_sig = WO'($signed(terms[i][C_INT_W-1:0]));
        end else begin : g_prod_lane
            // Product already sign-extended to the magnitude width
            assign int_sig = WO'($signed(mag));
        end

        assign sigs_d[i]   = is_int ? int_sig : fp_sig;
        assign sticky_d[i] = ~is_int & fp_sticky;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        is_int_q    <= is_int;
        tag_q       <= tag;
        max_exp_q   <= max_exp;
        sigs        <= sigs_d;
        sticky_bits <= sticky_d;
    end

endmodule

// File: fedp_top.f
common/fedp_pkg.sv
design/fedp_mul.sv
design/fedp_exp_max.sv
fedp_align/fedp_align.sv
design/fedp_reduce.sv
design/fedp_top.sv
sim/fedp_properties.sv
sim/fedp_tb.sv

// File: sim/fedp_properties.sv
`timescale 1ns/10ps

/*
 * Bound assertions on the top level of the dot-product engine
 *  - valid_out low in reset and at the first edge after it
 *  - valid_out follows valid_in four cycles later
 *  - request tag carried along the same delay
 */
module fedp_properties (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       valid_in,
    input logic [fedp_pkg::tag_w-1:0] tag,
    input logic                       valid_out,
    input fedp_pkg::result_t          result
);

    // Number of failed assertions so far
    int assert_failures = 0;

    a_reset_clear: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !valid_out)
        else begin
            assert_failures++;
            $error("valid_out is high in reset or at the first edge after it");
        end

    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in, 4))
        else begin
            assert_failures++;
            $error("valid_out does not follow valid_in by four cycles");
        end

    a_tag_latency: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (result.tag == $past(tag, 4)))
        else begin
            assert_failures++;
            $error("result tag differs from the tag sampled four cycles earlier");
        end

endmodule

bind fedp_top fedp_properties fedp_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .tag       (tag),
    .valid_out (valid_out),
    .result    (result)
);

// File: sim/fedp_tb.sv
`timescale 1ns/10ps

/*
 * Testbench of the dot-product engine
 *  - clock, reset and falling-edge stimulus
 *  - reference model and in-order result monitor
 *  - directed tests and a random request stream
 */
module fedp_tb;

    localparam int num_prod = fedp_pkg::num_terms - 1;

    logic                            clk;
    logic                            rst_n;
    logic                            valid_in;
    logic [fedp_pkg::tag_w-1:0]      tag;
    logic                            is_int;
    fedp_pkg::fp_op_t [num_prod-1:0] a_ops;
    fedp_pkg::fp_op_t [num_prod-1:0] b_ops;
    fedp_pkg::term_t                 c_term;
    logic                            valid_out;
    fedp_pkg::result_t               result;

    fedp_pkg::result_t          expected_q[$];
    fedp_pkg::result_t          want;
    logic [fedp_pkg::tag_w-1:0] next_tag;
    int                         error_count;
    int                         sent_count;
    int                         recv_count;
    logic                       timed_out;
    int unsigned                seed_state;

    fedp_top fedp_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .tag       (tag),
        .is_int    (is_int),
        .a_ops     (a_ops),
        .b_ops     (b_ops),
        .c_term    (c_term),
        .valid_out (valid_out),
        .result    (result)
    );

    always #50 clk = ~clk;

    function automatic fedp_pkg::fp_op_t fp_operand(input logic s, input logic [4:0] e,
                                                    input logic [9:0] f);
        return fedp_pkg::fp_op_t'({s, e, f});
    endfunction

    function automatic fedp_pkg::term_t term_value(input logic s, input logic [9:0] e,
                                                   input logic [21:0] m);
        return fedp_pkg::term_t'({s, e, m});
    endfunction

    function automatic fedp_pkg::fp_op_t int_operand(input logic [7:0] v);
        return fedp_pkg::fp_op_t'({8'h00, v});
    endfunction

    function automatic fedp_pkg::term_t int_addend(input logic [23:0] v);
        return fedp_pkg::term_t'({9'h000, v});
    endfunction

    // Expected result from products, common exponent, truncating shifts and sum
    function automatic fedp_pkg::result_t model_result(
        input fedp_pkg::fp_op_t [num_prod-1:0] a,
        input fedp_pkg::fp_op_t [num_prod-1:0] b,
        input fedp_pkg::term_t                 c,
        input logic                            int_mode,
        input logic [fedp_pkg::tag_w-1:0]      req_tag
    );
        fedp_pkg::result_t r;
        int                lane_exp [fedp_pkg::num_terms];
        longint            lane_mag [fedp_pkg::num_terms];
        logic              lane_neg [fedp_pkg::num_terms];
        int                top_exp;
        int                gap;
        longint            kept;
        longint            acc;
        logic              lost;
        acc     = 0;
        top_exp = 0;
        lost    = 1'b0;
        for (int i = 0; i < num_prod; i++) begin
            lane_neg[i] = a[i].sign ^ b[i].sign;
            lane_exp[i] = int'(a[i].exp) + int'(b[i].exp);
            lane_mag[i] = 0;
            if (a[i].exp != 0 && b[i].exp != 0) begin
                lane_mag[i] = longint'({1'b1, a[i].frac}) * longint'({1'b1, b[i].frac});
            end
            if (int_mode) begin
                acc += longint'($signed(a[i][7:0])) * longint'($signed(b[i][7:0]));
            end
        end
        lane_neg[num_prod] = c.sign;
        lane_exp[num_prod] = int'(c.exp);
        lane_mag[num_prod] = longint'(c.mag);
        if (int_mode) begin
            acc += longint'($signed(c[23:0]));
        end else begin
            for (int i = 0; i < fedp_pkg::num_terms; i++) begin
                top_exp = (lane_exp[i] > top_exp) ? lane_exp[i] : top_exp;
            end
            for (int i = 0; i < fedp_pkg::num_terms; i++) begin
                gap  = top_exp - lane_exp[i];
                // Any gap of mag_w or more clears the lane, saturated or not
                kept = (gap >= fedp_pkg::mag_w) ? 0 : (lane_mag[i] >> gap);
                lost |= ((kept << gap) != lane_mag[i]);
                acc += lane_neg[i] ? -kept : kept;
            end
        end
        r.sum     = fedp_pkg::sum_w'(acc);
        r.max_exp = fedp_pkg::exp_w'(top_exp);
        r.sticky  = lost;
        r.is_int  = int_mode;
        r.tag     = req_tag;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // One expected entry per valid_out, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n && valid_out) begin
            recv_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Result with tag %0h arrived with no request pending", result.tag);
            end else begin
                want = expected_q.pop_front();
                check_value("result.sum", 64'(result.sum), 64'(want.sum));
                check_value("result.max_exp", 64'(result.max_exp), 64'(want.max_exp));
                check_value("result.sticky", 64'(result.sticky), 64'(want.sticky));
                check_value("result.is_int", 64'(result.is_int), 64'(want.is_int));
                check_value("result.tag", 64'(result.tag), 64'(want.tag));
            end
        end
    end

    task automatic send_request(input fedp_pkg::fp_op_t [num_prod-1:0] a,
                                input fedp_pkg::fp_op_t [num_prod-1:0] b,
                                input fedp_pkg::term_t c, input logic int_mode);
        @(negedge clk);
        valid_in = 1'b1;
        tag      = next_tag;
        is_int   = int_mode;
        a_ops    = a;
        b_ops    = b;
        c_term   = c;
        expected_q.push_back(model_result(a, b, c, int_mode, next_tag));
        next_tag = next_tag + 1'b1;
        sent_count++;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            error_count++;
            timed_out = 1'b1;
            $display("Timeout: %0d results did not arrive within %0d cycles",
                     expected_q.size(), limit);
        end
    endtask

    task automatic test_equal_exp();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        for (int i = 0; i < num_prod; i++) begin
            a[i] = fp_operand(1'b0, 5'(12 + i), 10'(i * 300 + 1));
            b[i] = fp_operand(1'b0, 5'(18 - i), 10'h3ff);
        end
        send_request(a, b, term_value(1'b0, 10'd30, 22'h3fffff), 1'b0);
    endtask

    task automatic test_align_loss();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < num_prod; i++) begin
                a[i] = fp_operand(1'b0, 5'(15 - 2 * i), 10'((k == 0) ? 341 + i : 0));
                b[i] = fp_operand(1'(i % 2), 5'd15, 10'((k == 0) ? 683 : 0));
            end
            // Second pass has power-of-two magnitudes, no bit is shifted out
            send_request(a, b, term_value(1'b0, 10'd19, (k == 0) ? 22'h3fffff : 22'h200000),
                         1'b0);
        end
    endtask

    task automatic test_overshift();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        for (int i = 0; i < num_prod; i++) begin
            a[i] = fp_operand(1'b0, 5'((i == 3) ? 0 : 15), 10'(i * 200 + 7));
            b[i] = fp_operand(1'b1, 5'd15, 10'h0f0);
        end
        // Gaps to C of 256 and above, low 8 bits of the gap below mag_w
        send_request(a, b, term_value(1'b0, 10'd286, 22'h2aaaaa), 1'b0);
        a[0] = fp_operand(1'b0, 5'd25, 10'h123);
        b[0] = fp_operand(1'b0, 5'd25, 10'h321);
        a[1] = fp_operand(1'b1, 5'd20, 10'h001);
        b[1] = fp_operand(1'b0, 5'd8, 10'h000);
        a[2] = fp_operand(1'b0, 5'd0, 10'h3ff);
        b[2] = fp_operand(1'b0, 5'd20, 10'h3ff);
        a[3] = fp_operand(1'b0, 5'd10, 10'h0aa);
        b[3] = fp_operand(1'b1, 5'd10, 10'h055);
        send_request(a, b, term_value(1'b0, 10'd5, 22'h000001), 1'b0);
        for (int i = 0; i < num_prod; i++) begin
            a[i].exp = 5'd0;
        end
        send_request(a, b, term_value(1'b1, 10'd400, 22'h0), 1'b0);
    endtask

    task automatic test_signs();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        // Lanes 0 and 1 cancel, so do lanes 2 and 3
        for (int i = 0; i < num_prod; i++) begin
            a[i] = fp_operand(1'(i % 2), 5'd15, (i < 2) ? 10'h2aa : 10'h3ff);
            b[i] = fp_operand(1'b0, 5'd14, (i < 2) ? 10'h155 : 10'h001);
        end
        send_request(a, b, term_value(1'b0, 10'd0, 22'h0), 1'b0);
        for (int i = 0; i < num_prod; i++) begin
            a[i] = fp_operand(1'(i % 2), 5'(15 - i), 10'(97 * i + 5));
            b[i] = fp_operand(1'(i / 2), 5'd14, 10'(411 - 50 * i));
        end
        send_request(a, b, term_value(1'b1, 10'd28, 22'h0abcde), 1'b0);
    endtask

    task automatic test_int_mode();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        for (int i = 0; i < num_prod; i++) begin
            a[i] = int_operand(8'h80);
            b[i] = int_operand(8'h80);
        end
        send_request(a, b, int_addend(24'h7fffff), 1'b1);
        for (int i = 0; i < num_prod; i++) begin
            a[i] = int_operand(8'h7f);
        end
        send_request(a, b, int_addend(24'h800000), 1'b1);
        a = {int_operand(8'h00), int_operand(8'hff), int_operand(8'h7f), int_operand(8'h80)};
        b = {int_operand(8'h80), int_operand(8'hff), int_operand(8'h7f), int_operand(8'h7f)};
        send_request(a, b, int_addend(24'hffffff), 1'b1);
    endtask

    task automatic test_streaming();
        fedp_pkg::fp_op_t [num_prod-1:0] a;
        fedp_pkg::fp_op_t [num_prod-1:0] b;
        fedp_pkg::term_t                 c;
        logic                            mode;
        for (int n = 0; n < 200; n++) begin
            mode = 1'($urandom_range(0, 1));
            for (int i = 0; i < num_prod; i++) begin
                a[i] = fp_operand(1'($urandom), 5'($urandom_range(0, 30)), 10'($urandom));
                b[i] = fp_operand(1'($urandom), 5'($urandom_range(0, 30)), 10'($urandom));
            end
            c = term_value(1'($urandom), 10'($urandom_range(0, 90)), 22'($urandom));
            send_request(a, b, c, mode);
            // Back-to-back first, then a random valid pattern
            if (n >= 100) begin
                repeat ($urandom_range(0, 3)) drive_idle();
            end
        end
    endtask

    task automatic run_test(input int index);
        case (index)
            0: test_equal_exp();
            1: test_align_loss();
            2: test_overshift();
            3: test_signs();
            4: test_int_mode();
            default: test_streaming();
        endcase
    endtask

    task automatic finish_run();
        int failures;
        check_value("result_count", 64'(recv_count), 64'(sent_count));
        failures = error_count + fedp_top_inst.fedp_properties_inst.assert_failures;
        $display("Summary: %0d check errors, %0d assertion failures, %0d of %0d results",
                 error_count, fedp_top_inst.fedp_properties_inst.assert_failures,
                 recv_count, sent_count);
        if (failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        seed_state  = $urandom(32'h973d653a);
        clk         = 1'b0;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        tag         = '0;
        is_int      = 1'b0;
        a_ops       = '0;
        b_ops       = '0;
        c_term      = '0;
        next_tag    = '0;
        error_count = 0;
        sent_count  = 0;
        recv_count  = 0;
        timed_out   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < 6 && !timed_out; t++) begin
            run_test(t);
            drive_idle();
            wait_drain(50);
        end
        finish_run();
    end

endmodule
